// ==== include/bus_defs.svh ====
//------------------------------
// I/O page base and console switch/display register address,
// shared by the bus package and the testbench
//------------------------------
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// first byte address of the I/O page (octal 760000)
`define io_page_base 18'o760000

// console switch register on read, display register on write
`define console_reg_addr 18'o777570

`endif

// ==== design/bus_pkg.sv ====
//------------------------------
// bus slave package: widths, address map, wait counts
// and the bus cycle state encoding
//------------------------------
`include "bus_defs.svh"

package bus_pkg;

   // widths
   localparam int addr_width      = 18;
   localparam int data_width      = 16;
   localparam int sram_addr_width = 17;
   localparam int timer_width     = 5;

   // address map
   localparam logic [addr_width-1:0] io_page_base     = `io_page_base;
   localparam logic [addr_width-1:0] console_reg_addr = `console_reg_addr;

   // cycles the sram strobes are held, and the nonexistent memory timeout
   localparam int sram_wait_cycles   = 2;
   localparam int nxm_timeout_cycles = 16;

   typedef enum logic [2:0] {
      st_idle,
      st_sram_cycle,
      st_console_cycle,
      st_nxm_wait,
      st_reply,
      st_release
   } bus_state_t;

endpackage

// ==== design/bus_wait_timer.sv ====
//------------------------------
// loadable down-counter for sram strobe
// wait and nonexistent address timeout
//------------------------------
`timescale 1ns/1ps

module bus_wait_timer (
   input  logic                             sysclk,
   input  logic                             rst_n,
   input  logic                             timer_load,
   input  logic [bus_pkg::timer_width-1:0]  timer_count,
   output logic                             timer_expired
);
   import bus_pkg::*;

   logic [timer_width-1:0] count;
   logic                   running;

   always_ff @(posedge sysclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         count   <= '0;
         running <= 1'b0;
      end
      else if (timer_load)
      begin
         count   <= timer_count;
         running <= 1'b1;
      end
      else if (running)
      begin
         // stop once the zero cycle has been signalled
         if (count == '0)
            running <= 1'b0;
         else
            count <= count - 1'b1;
      end
   end

   assign timer_expired = running && (count == '0);

endmodule

// ==== design/bus_cycle_fsm.sv ====
//------------------------------
// bus cycle FSM: address decode, block steering,
// ack/error generation and four-phase release
//------------------------------
`timescale 1ns/1ps

module bus_cycle_fsm (
   input  logic                             sysclk,
   input  logic                             rst_n,
   input  logic [bus_pkg::addr_width-1:0]   bus_addr,
   input  logic                             bus_rd,
   input  logic                             bus_wr,
   output logic                             bus_ack,
   output logic                             bus_error,
   output logic                             timer_load,
   output logic [bus_pkg::timer_width-1:0]  timer_count,
   input  logic                             timer_expired,
   output logic                             sram_start,
   output logic                             sram_stop,
   output logic                             sram_write,
   output logic                             console_rd,
   output logic                             console_wr,
   output logic                             reply_sel_console
);
   import bus_pkg::*;

   // the timer expires one cycle after it counts down to zero
   localparam logic [timer_width-1:0] sram_load = timer_width'(sram_wait_cycles - 1);
   localparam logic [timer_width-1:0] nxm_load  = timer_width'(nxm_timeout_cycles - 1);

   bus_state_t state;
   logic       req;
   logic       is_ram;
   logic       is_console;

   assign req        = bus_rd | bus_wr;
   assign is_ram     = (bus_addr < io_page_base);
   // word compare, so the odd byte of the register decodes too
   assign is_console = (bus_addr[addr_width-1:1] == console_reg_addr[addr_width-1:1]);

   //------------------------------
   // block steering
   //------------------------------
   always_comb
   begin
      timer_load  = (state == st_idle) && req && !is_console;
      timer_count = is_ram ? sram_load : nxm_load;
      sram_start  = (state == st_idle) && req && is_ram;
      sram_write  = bus_wr;
      sram_stop   = (state == st_sram_cycle) && timer_expired;
      console_rd  = (state == st_console_cycle) && bus_rd;
      console_wr  = (state == st_console_cycle) && bus_wr;
   end

   //------------------------------
   // state and reply registers
   //------------------------------
   always_ff @(posedge sysclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state             <= st_idle;
         bus_ack           <= 1'b0;
         bus_error         <= 1'b0;
         reply_sel_console <= 1'b0;
      end
      else
      begin
         case (state)
            st_idle:
               if (req)
               begin
                  reply_sel_console <= !is_ram && is_console;
                  if (is_ram)
                     state <= st_sram_cycle;
                  else if (is_console)
                     state <= st_console_cycle;
                  else
                     state <= st_nxm_wait;
               end
            st_sram_cycle:
               if (timer_expired)
               begin
                  state   <= st_reply;
                  bus_ack <= 1'b1;
               end
            st_console_cycle:
            begin
               state   <= st_reply;
               bus_ack <= 1'b1;
            end
            st_nxm_wait:
               if (timer_expired)
               begin
                  state     <= st_reply;
                  bus_error <= 1'b1;
               end
            // hold the reply as long as the master holds its request
            st_reply:
               if (!req)
               begin
                  state     <= st_release;
                  bus_ack   <= 1'b0;
                  bus_error <= 1'b0;
               end
            st_release:
               state <= st_idle;
            default:
               state <= st_idle;
         endcase
      end
   end

endmodule

// ==== design/sram_port.sv ====
//------------------------------
// external async sram pin driver:
// byte lanes, strobes, read capture
//------------------------------
`timescale 1ns/1ps

module sram_port (
   input  logic                                 sysclk,
   input  logic                                 rst_n,
   input  logic [bus_pkg::addr_width-1:0]       bus_addr,
   input  logic [bus_pkg::data_width-1:0]       bus_data_in,
   input  logic                                 bus_byte_op,
   input  logic                                 sram_start,
   input  logic                                 sram_stop,
   input  logic                                 sram_write,
   output logic [bus_pkg::data_width-1:0]       sram_rdata,
   output logic [bus_pkg::sram_addr_width-1:0]  sram_a,
   output logic [bus_pkg::data_width-1:0]       sram_dout,
   input  logic [bus_pkg::data_width-1:0]       sram_din,
   output logic                                 sram_dq_oe,
   output logic                                 sram_ce_n,
   output logic                                 sram_oe_n,
   output logic                                 sram_we_n,
   output logic                                 sram_ub_n,
   output logic                                 sram_lb_n
);
   import bus_pkg::*;

   //------------------------------
   // strobes and lane enables
   //------------------------------
   always_ff @(posedge sysclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sram_ce_n  <= 1'b1;
         sram_oe_n  <= 1'b1;
         sram_we_n  <= 1'b1;
         sram_dq_oe <= 1'b0;
         sram_ub_n  <= 1'b1;
         sram_lb_n  <= 1'b1;
      end
      else if (sram_start)
      begin
         sram_ce_n  <= 1'b0;
         sram_oe_n  <= sram_write;
         sram_we_n  <= !sram_write;
         sram_dq_oe <= sram_write;
         // address bit 0 picks the lane for byte cycles
         sram_ub_n  <= bus_byte_op && !bus_addr[0];
         sram_lb_n  <= bus_byte_op && bus_addr[0];
      end
      else if (sram_stop)
      begin
         sram_ce_n  <= 1'b1;
         sram_oe_n  <= 1'b1;
         sram_we_n  <= 1'b1;
         sram_dq_oe <= 1'b0;
         sram_ub_n  <= 1'b1;
         sram_lb_n  <= 1'b1;
      end
   end

   //------------------------------
   // address, write data, read data
   //------------------------------
   always_ff @(posedge sysclk)
   begin
      if (sram_start)
      begin
         sram_a    <= bus_addr[addr_width-1:1];
         // a byte goes out on both lanes, the lane enable selects it
         sram_dout <= bus_byte_op ? {2{bus_data_in[7:0]}} : bus_data_in;
      end
      // oe_n low marks a read cycle in progress
      if (sram_stop && !sram_oe_n)
         sram_rdata <= sram_din;
   end

endmodule

// ==== design/console_regs.sv ====
//------------------------------
// console switch register (read)
// and display register (write) on leds
//------------------------------
`timescale 1ns/1ps

module console_regs (
   input  logic                            sysclk,
   input  logic                            rst_n,
   input  logic [7:0]                      switches,
   input  logic [bus_pkg::data_width-1:0]  bus_data_in,
   input  logic                            bus_byte_op,
   input  logic                            bus_addr0,
   input  logic                            console_wr,
   input  logic                            console_rd,
   output logic [bus_pkg::data_width-1:0]  console_rdata,
   output logic [7:0]                      led
);
   import bus_pkg::*;

   logic [data_width-1:0] display_reg;

   // display register, byte data arrives in the low byte
   always_ff @(posedge sysclk or negedge rst_n)
   begin
      if (!rst_n)
         display_reg <= '0;
      else if (console_wr)
      begin
         if (!bus_byte_op)
            display_reg <= bus_data_in;
         else if (bus_addr0)
            display_reg[15:8] <= bus_data_in[7:0];
         else
            display_reg[7:0] <= bus_data_in[7:0];
      end
   end

   // sample the switches when the register is read
   always_ff @(posedge sysclk)
   begin
      if (console_rd)
         console_rdata <= {{(data_width-8){1'b0}}, switches};
   end

   assign led = display_reg[7:0];

endmodule

// ==== design/bus_top.sv ====
//------------------------------
// bus slave top: FSM, wait timer,
// sram port, console registers
//------------------------------
`timescale 1ns/1ps

module bus_top (
   input  logic                                 sysclk,
   input  logic                                 rst_n,
   input  logic [bus_pkg::addr_width-1:0]       bus_addr,
   input  logic [bus_pkg::data_width-1:0]       bus_data_in,
   input  logic                                 bus_rd,
   input  logic                                 bus_wr,
   input  logic                                 bus_byte_op,
   input  logic [7:0]                           switches,
   output logic [bus_pkg::data_width-1:0]       bus_data_out,
   output logic                                 bus_ack,
   output logic                                 bus_error,
   output logic [7:0]                           led,
   output logic [bus_pkg::sram_addr_width-1:0]  sram_a,
   output logic [bus_pkg::data_width-1:0]       sram_dout,
   input  logic [bus_pkg::data_width-1:0]       sram_din,
   output logic                                 sram_dq_oe,
   output logic                                 sram_ce_n,
   output logic                                 sram_oe_n,
   output logic                                 sram_we_n,
   output logic                                 sram_ub_n,
   output logic                                 sram_lb_n
);
   import bus_pkg::*;

   logic                   timer_load;
   logic [timer_width-1:0] timer_count;
   logic                   timer_expired;
   logic                   sram_start;
   logic                   sram_stop;
   logic                   sram_write;
   logic                   console_rd;
   logic                   console_wr;
   logic                   reply_sel_console;
   logic [data_width-1:0]  sram_rdata;
   logic [data_width-1:0]  console_rdata;

   bus_cycle_fsm u_fsm (
      .sysclk            (sysclk),
      .rst_n             (rst_n),
      .bus_addr          (bus_addr),
      .bus_rd            (bus_rd),
      .bus_wr            (bus_wr),
      .bus_ack           (bus_ack),
      .bus_error         (bus_error),
      .timer_load        (timer_load),
      .timer_count       (timer_count),
      .timer_expired     (timer_expired),
      .sram_start        (sram_start),
      .sram_stop         (sram_stop),
      .sram_write        (sram_write),
      .console_rd        (console_rd),
      .console_wr        (console_wr),
      .reply_sel_console (reply_sel_console)
   );

   bus_wait_timer u_timer (
      .sysclk        (sysclk),
      .rst_n         (rst_n),
      .timer_load    (timer_load),
      .timer_count   (timer_count),
      .timer_expired (timer_expired)
   );

   sram_port u_sram (
      .sysclk      (sysclk),
      .rst_n       (rst_n),
      .bus_addr    (bus_addr),
      .bus_data_in (bus_data_in),
      .bus_byte_op (bus_byte_op),
      .sram_start  (sram_start),
      .sram_stop   (sram_stop),
      .sram_write  (sram_write),
      .sram_rdata  (sram_rdata),
      .sram_a      (sram_a),
      .sram_dout   (sram_dout),
      .sram_din    (sram_din),
      .sram_dq_oe  (sram_dq_oe),
      .sram_ce_n   (sram_ce_n),
      .sram_oe_n   (sram_oe_n),
      .sram_we_n   (sram_we_n),
      .sram_ub_n   (sram_ub_n),
      .sram_lb_n   (sram_lb_n)
   );

   console_regs u_console (
      .sysclk        (sysclk),
      .rst_n         (rst_n),
      .switches      (switches),
      .bus_data_in   (bus_data_in),
      .bus_byte_op   (bus_byte_op),
      .bus_addr0     (bus_addr[0]),
      .console_wr    (console_wr),
      .console_rd    (console_rd),
      .console_rdata (console_rdata),
      .led           (led)
   );

   // read data source follows the block that served the cycle
   assign bus_data_out = reply_sel_console ? console_rdata : sram_rdata;

endmodule

// ==== dv/sram_model.sv ====
//------------------------------
// behavioral async sram, 16 bits
// wide, upper and lower byte enables
//------------------------------
`timescale 1ns/1ps

module sram_model (
   input  logic [bus_pkg::sram_addr_width-1:0]  sram_a,
   input  logic [bus_pkg::data_width-1:0]       sram_dout,
   output logic [bus_pkg::data_width-1:0]       sram_din,
   input  logic                                 sram_dq_oe,
   input  logic                                 sram_ce_n,
   input  logic                                 sram_oe_n,
   input  logic                                 sram_we_n,
   input  logic                                 sram_ub_n,
   input  logic                                 sram_lb_n
);
   import bus_pkg::*;

   logic [data_width-1:0] mem [0:(2**sram_addr_width)-1];
   logic                  reading;

   // address, data and lanes all settle in the same step as we_n falls
   always @(negedge sram_we_n)
   begin
      #1;
      if (!sram_ce_n && !sram_we_n)
      begin
         if (!sram_lb_n)
            mem[sram_a][7:0] = sram_dout[7:0];
         if (!sram_ub_n)
            mem[sram_a][15:8] = sram_dout[15:8];
      end
   end

   // drive the pins only while the controller has them released
   assign reading  = !sram_ce_n && !sram_oe_n && sram_we_n && !sram_dq_oe;
   assign sram_din = {(reading && !sram_ub_n) ? mem[sram_a][15:8] : 8'hxx,
                      (reading && !sram_lb_n) ? mem[sram_a][7:0] : 8'hxx};

endmodule

// ==== dv/bus_top_sva.sv ====
//------------------------------
// bound checks: handshake order,
// reset values, sram strobes
//------------------------------
`timescale 1ns/1ps

module bus_top_sva (
   input logic       sysclk,
   input logic       rst_n,
   input logic       bus_rd,
   input logic       bus_wr,
   input logic       bus_ack,
   input logic       bus_error,
   input logic       sram_ce_n,
   input logic       sram_oe_n,
   input logic       sram_we_n,
   input logic       sram_dq_oe,
   input logic [7:0] led
);
   logic        req;
   logic        reply;
   int unsigned assert_fails = 0;

   assign req   = bus_rd || bus_wr;
   assign reply = bus_ack || bus_error;

   //------------------------------
   // four-phase handshake
   //------------------------------
   reply_one_hot: assert property (@(posedge sysclk) disable iff (!rst_n)
      !(bus_ack && bus_error))
   else
   begin
      $error("bus_ack and bus_error high together");
      assert_fails++;
   end

   reply_after_request: assert property (@(posedge sysclk) disable iff (!rst_n)
      $rose(reply) |-> $past(req))
   else
   begin
      $error("reply rose without a request");
      assert_fails++;
   end

   // reply is held as long as the master holds its request
   reply_held: assert property (@(posedge sysclk) disable iff (!rst_n)
      (reply && req) |=> reply)
   else
   begin
      $error("reply dropped while the request was still high");
      assert_fails++;
   end

   reply_release: assert property (@(posedge sysclk) disable iff (!rst_n)
      (reply && !req) |=> !reply)
   else
   begin
      $error("reply not dropped one cycle after the request dropped");
      assert_fails++;
   end

   //------------------------------
   // sram strobes and reset values
   //------------------------------
   strobe_legal: assert property (@(posedge sysclk) disable iff (!rst_n)
      !(!sram_we_n && !sram_oe_n))
   else
   begin
      $error("sram_we_n and sram_oe_n low together");
      assert_fails++;
   end

   reset_values: assert property (@(posedge sysclk)
      !rst_n |-> (!bus_ack && !bus_error && sram_we_n && sram_oe_n && sram_ce_n
                  && !sram_dq_oe && led == 8'h00))
   else
   begin
      $error("control output active during reset");
      assert_fails++;
   end

endmodule

// ==== dv/tb_bus_top.sv ====
//------------------------------
// bus slave testbench: four-phase bus
// cycles, data checks, watchdog
//------------------------------
`timescale 1ns/1ps
`include "bus_defs.svh"

module tb_bus_top;
   import bus_pkg::*;

   localparam int num_tests   = 5;
   localparam int reply_limit = 40;
   // 40 cycles per test, plus reset and margin, at 8 ns
   localparam int watchdog_ns = (num_tests * 40 + 200) * 8;
   localparam logic [addr_width-1:0] console_addr = `console_reg_addr;

   logic                       sysclk = 1'b0;
   logic                       rst_n  = 1'b1;
   logic [addr_width-1:0]      bus_addr;
   logic [data_width-1:0]      bus_data_in;
   logic                       bus_rd;
   logic                       bus_wr;
   logic                       bus_byte_op;
   logic [7:0]                 switches;
   logic [data_width-1:0]      bus_data_out;
   logic                       bus_ack;
   logic                       bus_error;
   logic [7:0]                 led;
   logic [sram_addr_width-1:0] sram_a;
   logic [data_width-1:0]      sram_dout;
   logic [data_width-1:0]      sram_din;
   logic                       sram_dq_oe;
   logic                       sram_ce_n;
   logic                       sram_oe_n;
   logic                       sram_we_n;
   logic                       sram_ub_n;
   logic                       sram_lb_n;

   integer                seed;
   string                 test_name;
   int                    errors;
   int                    errors_at_start;
   int                    tests_ok;
   int                    tests_bad;
   logic [data_width-1:0] last_rdata;
   int                    last_edge;
   logic                  last_ack;
   logic                  last_error;

   always #4 sysclk = ~sysclk;

   bus_top u_dut (.*);

   sram_model u_sram (.*);

   bind bus_top bus_top_sva u_sva (
      .sysclk     (sysclk),
      .rst_n      (rst_n),
      .bus_rd     (bus_rd),
      .bus_wr     (bus_wr),
      .bus_ack    (bus_ack),
      .bus_error  (bus_error),
      .sram_ce_n  (sram_ce_n),
      .sram_oe_n  (sram_oe_n),
      .sram_we_n  (sram_we_n),
      .sram_dq_oe (sram_dq_oe),
      .led        (led)
   );

   //------------------------------
   // checks and reporting
   //------------------------------
   task automatic compare_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         $display("Error: %s %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic confirm(input logic cond, input string what);
      assert (cond)
      else
      begin
         $display("%s: %s", test_name, what);
         errors++;
      end
   endtask

   // reply kind and the edge it arrived on, counted from the request
   task automatic check_reply(input logic want_error, input int want_edge);
      if (want_error)
         confirm(last_error && !last_ack, "expected bus_error but saw ack or no reply");
      else
         confirm(last_ack && !last_error, "expected bus_ack but saw error or no reply");
      compare_value("reply edge", 32'(want_edge), 32'(last_edge));
   endtask

   task automatic close_test();
      if (errors == errors_at_start)
      begin
         tests_ok++;
         $display("%-14s ok", test_name);
      end
      else
      begin
         tests_bad++;
         $display("%-14s FAIL with %0d errors", test_name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   function automatic logic [addr_width-1:0] random_ram_addr();
      logic [31:0] r;
      r = $random(seed);
      return (r[17:0] % `io_page_base) & 18'h3fffe;
   endfunction

   //------------------------------
   // four-phase bus cycles
   //------------------------------
   task automatic run_cycle(input logic write, input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] wdata, input logic byte_op,
                            input int hold);
      @(posedge sysclk);
      #1;
      bus_addr    = addr;
      bus_data_in = wdata;
      bus_byte_op = byte_op;
      bus_wr      = write;
      bus_rd      = !write;
      last_edge   = 0;
      while (!(bus_ack || bus_error) && last_edge < reply_limit)
      begin
         @(posedge sysclk);
         #1;
         last_edge++;
      end
      confirm(bus_ack || bus_error, "no reply within the edge limit");
      last_ack   = bus_ack;
      last_error = bus_error;
      last_rdata = bus_data_out;
      // master keeps its request up, reply must stay
      for (int i = 0; i < hold; i++)
      begin
         @(posedge sysclk);
         #1;
         confirm(bus_ack || bus_error, "reply dropped while the request was held");
      end
      bus_rd = 1'b0;
      bus_wr = 1'b0;
      @(posedge sysclk);
      #1;
      confirm(!(bus_ack || bus_error), "reply still high one edge after the request dropped");
   endtask

   task automatic bus_read(input logic [addr_width-1:0] addr, input int hold);
      run_cycle(1'b0, addr, '0, 1'b0, hold);
   endtask

   task automatic bus_write(input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] wdata, input logic byte_op,
                            input int hold);
      run_cycle(1'b1, addr, wdata, byte_op, hold);
   endtask

   //------------------------------
   // test sequence
   //------------------------------
   initial
   begin
      logic [addr_width-1:0] addr;
      logic [data_width-1:0] word;
      logic [7:0]            lane_byte;
      logic [7:0]            junk;

      seed            = 32'h6edd;
      errors          = 0;
      errors_at_start = 0;
      tests_ok        = 0;
      tests_bad       = 0;
      bus_addr        = '0;
      bus_data_in     = '0;
      bus_rd          = 1'b0;
      bus_wr          = 1'b0;
      bus_byte_op     = 1'b0;
      switches        = 8'h00;
      #1;
      rst_n = 1'b0;
      repeat (8) @(posedge sysclk);
      #1;
      rst_n = 1'b1;

      test_name = "word_rw";
      for (int i = 0; i < 6; i++)
      begin
         addr = random_ram_addr();
         word = 16'($random(seed));
         bus_write(addr, word, 1'b0, 0);
         check_reply(1'b0, 3);
         bus_read(addr, 0);
         check_reply(1'b0, 3);
         compare_value("read data", 32'(word), 32'(last_rdata));
      end
      close_test();

      test_name = "byte_merge";
      for (int i = 0; i < 3; i++)
      begin
         addr      = random_ram_addr();
         word      = 16'($random(seed));
         lane_byte = 8'($random(seed));
         junk      = 8'($random(seed));
         bus_write(addr, word, 1'b0, 0);
         bus_write(addr | 18'd1, {junk, lane_byte}, 1'b1, 0);
         check_reply(1'b0, 3);
         bus_read(addr, 0);
         compare_value("odd byte merge", 32'({lane_byte, word[7:0]}), 32'(last_rdata));
         word      = 16'($random(seed));
         lane_byte = 8'($random(seed));
         bus_write(addr, word, 1'b0, 0);
         bus_write(addr, {junk, lane_byte}, 1'b1, 0);
         bus_read(addr, 0);
         compare_value("even byte merge", 32'({word[15:8], lane_byte}), 32'(last_rdata));
      end
      close_test();

      test_name = "console_read";
      for (int i = 0; i < 2; i++)
      begin
         switches = 8'($random(seed));
         bus_read(console_addr, 0);
         check_reply(1'b0, 2);
         compare_value("switch word", {24'h0, switches}, 32'(last_rdata));
      end
      close_test();

      test_name = "console_write";
      word      = 16'($random(seed));
      bus_write(console_addr, word, 1'b0, 0);
      check_reply(1'b0, 2);
      compare_value("led after word write", 32'(word[7:0]), 32'(led));
      junk = 8'($random(seed));
      bus_write(console_addr | 18'd1, {8'h00, junk}, 1'b1, 0);
      check_reply(1'b0, 2);
      compare_value("led after odd byte write", 32'(word[7:0]), 32'(led));
      close_test();

      test_name = "nxm_timeout";
      bus_read(`io_page_base, 0);
      check_reply(1'b1, 17);
      addr = console_addr;
      while (addr[addr_width-1:1] == console_addr[addr_width-1:1])
         addr = `io_page_base | (18'($random(seed)) & 18'o017777);
      bus_write(addr, 16'($random(seed)), 1'b0, 5);
      check_reply(1'b1, 17);
      close_test();

      $display("tests %0d, ok %0d, with errors %0d, assertion failures %0d",
               num_tests, tests_ok, tests_bad, u_dut.u_sva.assert_fails);
      if (tests_bad == 0 && u_dut.u_sva.assert_fails == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // watchdog against a DUT that never replies or releases
   initial
   begin
      #(watchdog_ns);
      $display("simulation hung, no finish after %0d ns", watchdog_ns);
      $display("test failed");
      $finish;
   end

endmodule

// ==== pdp11_bus.f ====
+incdir+include
design/bus_pkg.sv
design/bus_wait_timer.sv
design/bus_cycle_fsm.sv
design/sram_port.sv
design/console_regs.sv
design/bus_top.sv
dv/sram_model.sv
dv/bus_top_sva.sv
dv/tb_bus_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the bus slave testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_bus_top \
   -f pdp11_bus.f --Mdir obj_dir -o sim_bus_top
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_bus_top +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "test passed"; then
   exit 0
fi
exit 1
